// ==== logic/report_pkg.sv ====
package report_pkg;

	typedef logic [1:0] wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [31:0] nonce_t;
	typedef logic [9:0] bits_off_t;
	typedef logic [7:0] tx_byte_t;
	typedef logic [1:0] byte_count_t;
	typedef logic [2:0] bit_index_t;

	localparam wb_addr_t ADDR_CTRL = 2'd0;
	localparam wb_addr_t ADDR_NONCE = 2'd1;
	localparam wb_addr_t ADDR_BITS_OFF = 2'd2;
	localparam wb_addr_t ADDR_STATUS = 2'd3;

	localparam tx_byte_t CHAR_HEADER = 8'd100;
	localparam tx_byte_t CHAR_PING_ON = 8'd49;
	localparam tx_byte_t CHAR_PING_OFF = 8'd48;
	localparam tx_byte_t CHAR_FOOTER = 8'd52;

	localparam byte_count_t NONCE_LAST_INDEX = 2'd3;

	localparam int CLKS_PER_BIT = 16;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] baud_count_t;

	typedef enum logic [2:0] {
		IDLE, SEND_PING, SEND_NONCE, SEND_BITS_OFF_1, SEND_BITS_OFF_2, FOOTER
	} frame_state_t;
	typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;

endpackage

// ==== logic/wb_report_regs.sv ====
module wb_report_regs (
	input logic clk_i,
	input logic rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input report_pkg::wb_addr_t wb_adr_i,
	input report_pkg::wb_data_t wb_dat_i,
	output report_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,
	input logic reset_ping_waiting_i,
	input logic reset_nonce_waiting_i,
	output logic chip_enabled_o,
	output logic ping_waiting_o,
	output logic nonce_waiting_o,
	output report_pkg::nonce_t nonce_o,
	output report_pkg::bits_off_t bits_off_o
);

	logic wb_access;
	logic wb_write;
	report_pkg::wb_data_t read_data;

	// a new access is one that has not been acknowledged yet.
	assign wb_access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign wb_write = wb_access & wb_we_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_access;
		end
	end

	// a host write that sets a flag wins over a clear pulse in the same cycle.
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			chip_enabled_o <= 1'b0;
			ping_waiting_o <= 1'b0;
			nonce_waiting_o <= 1'b0;
		end else begin
			if (wb_write && wb_adr_i == report_pkg::ADDR_CTRL) begin
				chip_enabled_o <= wb_dat_i[0];
			end
			if (wb_write && wb_adr_i == report_pkg::ADDR_CTRL && wb_dat_i[1]) begin
				ping_waiting_o <= 1'b1;
			end else if (reset_ping_waiting_i) begin
				ping_waiting_o <= 1'b0;
			end
			if (wb_write && wb_adr_i == report_pkg::ADDR_NONCE) begin
				nonce_waiting_o <= 1'b1;
			end else if (reset_nonce_waiting_i) begin
				nonce_waiting_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (wb_write && wb_adr_i == report_pkg::ADDR_NONCE) begin
			nonce_o <= wb_dat_i;
		end
		if (wb_write && wb_adr_i == report_pkg::ADDR_BITS_OFF) begin
			bits_off_o <= wb_dat_i[9:0];
		end
	end

	always_comb begin
		case (wb_adr_i)
			report_pkg::ADDR_CTRL: read_data = report_pkg::wb_data_t'(chip_enabled_o);
			report_pkg::ADDR_NONCE: read_data = nonce_o;
			report_pkg::ADDR_BITS_OFF: read_data = report_pkg::wb_data_t'(bits_off_o);
			default: read_data = report_pkg::wb_data_t'({nonce_waiting_o, ping_waiting_o});
		endcase
	end

	// read data is registered so that it lines up with ack.
	always_ff @(posedge clk_i) begin
		if (wb_access && !wb_we_i) begin
			wb_dat_o <= read_data;
		end
	end

endmodule

// ==== logic/nonce_sequencer.sv ====
module nonce_sequencer (
	input logic clk_i,
	input logic rst_i,
	input report_pkg::nonce_t nonce_i,
	input report_pkg::bits_off_t bits_off_i,
	input logic reset_byte_counter_i,
	input logic decrement_byte_counter_i,
	output report_pkg::tx_byte_t nonce_byte_o,
	output report_pkg::bits_off_t nonce_bits_off_o,
	output logic byte_counter_zero_o
);

	report_pkg::nonce_t nonce_q;
	report_pkg::byte_count_t byte_counter;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			byte_counter <= '0;
		end else if (reset_byte_counter_i) begin
			byte_counter <= report_pkg::NONCE_LAST_INDEX;
		end else if (decrement_byte_counter_i) begin
			byte_counter <= byte_counter - 1'b1;
		end
	end

	// the frame works on its own copy, so host writes only reach the next frame.
	always_ff @(posedge clk_i) begin
		if (reset_byte_counter_i) begin
			nonce_q <= nonce_i;
			nonce_bits_off_o <= bits_off_i;
		end
	end

	// counter value three selects the most significant byte.
	assign nonce_byte_o = nonce_q[{byte_counter, 3'b000} +: 8];
	assign byte_counter_zero_o = (byte_counter == '0);

endmodule

// ==== logic/frame_sender.sv ====
module frame_sender (
	input logic clk_i,
	input logic rst_i,
	input logic tx_busy_i,
	input logic send_nonce_i,
	input logic send_ping_i,
	input logic byte_counter_zero_i,
	input logic chip_enabled_i,
	input report_pkg::tx_byte_t nonce_byte_i,
	input report_pkg::bits_off_t nonce_bits_off_i,
	output logic tx_new_o,
	output report_pkg::tx_byte_t tx_data_o,
	output logic reset_ping_waiting_o,
	output logic reset_nonce_waiting_o,
	output logic reset_byte_counter_o,
	output logic decrement_byte_counter_o
);

	report_pkg::frame_state_t state;
	report_pkg::frame_state_t next_state;

	// every state holds while the UART is busy and moves on once a byte is taken.
	always_comb begin
		next_state = state;
		tx_new_o = 1'b0;
		tx_data_o = '0;
		reset_ping_waiting_o = 1'b0;
		reset_nonce_waiting_o = 1'b0;
		reset_byte_counter_o = 1'b0;
		decrement_byte_counter_o = 1'b0;

		if (!tx_busy_i) begin
			case (state)
				report_pkg::IDLE: begin
					// a waiting nonce goes out before a waiting ping.
					if (chip_enabled_i && send_nonce_i) begin
						next_state = report_pkg::SEND_NONCE;
						reset_nonce_waiting_o = 1'b1;
						reset_byte_counter_o = 1'b1;
						tx_new_o = 1'b1;
						tx_data_o = report_pkg::CHAR_HEADER;
					end else if (chip_enabled_i && send_ping_i) begin
						next_state = report_pkg::SEND_PING;
						reset_ping_waiting_o = 1'b1;
						tx_new_o = 1'b1;
						tx_data_o = report_pkg::CHAR_HEADER;
					end
				end

				report_pkg::SEND_PING: begin
					next_state = report_pkg::FOOTER;
					tx_new_o = 1'b1;
					if (chip_enabled_i) begin
						tx_data_o = report_pkg::CHAR_PING_ON;
					end else begin
						tx_data_o = report_pkg::CHAR_PING_OFF;
					end
				end

				report_pkg::SEND_NONCE: begin
					decrement_byte_counter_o = 1'b1;
					tx_new_o = 1'b1;
					tx_data_o = nonce_byte_i;
					if (byte_counter_zero_i) begin
						next_state = report_pkg::SEND_BITS_OFF_1;
					end
				end

				report_pkg::SEND_BITS_OFF_1: begin
					next_state = report_pkg::SEND_BITS_OFF_2;
					tx_new_o = 1'b1;
					tx_data_o = nonce_bits_off_i[7:0];
				end

				report_pkg::SEND_BITS_OFF_2: begin
					next_state = report_pkg::FOOTER;
					tx_new_o = 1'b1;
					tx_data_o = report_pkg::tx_byte_t'(nonce_bits_off_i[9:8]);
				end

				report_pkg::FOOTER: begin
					next_state = report_pkg::IDLE;
					tx_new_o = 1'b1;
					tx_data_o = report_pkg::CHAR_FOOTER;
				end

				default: begin
					next_state = report_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= report_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx (
	input logic clk_i,
	input logic rst_i,
	input logic tx_new_i,
	input report_pkg::tx_byte_t tx_data_i,
	output logic tx_busy_o,
	output logic uart_tx_o
);

	report_pkg::uart_state_t state;
	report_pkg::baud_count_t clk_count;
	report_pkg::bit_index_t bit_index;
	report_pkg::tx_byte_t shift_q;
	logic bit_done;

	assign bit_done = (clk_count == report_pkg::baud_count_t'(report_pkg::CLKS_PER_BIT - 1));
	assign tx_busy_o = (state != report_pkg::UART_IDLE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= report_pkg::UART_IDLE;
			uart_tx_o <= 1'b1;
			clk_count <= '0;
			bit_index <= '0;
		end else begin
			clk_count <= bit_done ? '0 : clk_count + 1'b1;
			case (state)
				report_pkg::UART_IDLE: begin
					clk_count <= '0;
					if (tx_new_i) begin
						state <= report_pkg::UART_START;
						uart_tx_o <= 1'b0;
					end
				end
				report_pkg::UART_START: begin
					if (bit_done) begin
						state <= report_pkg::UART_DATA;
						uart_tx_o <= shift_q[0];
						bit_index <= '0;
					end
				end
				report_pkg::UART_DATA: begin
					if (bit_done) begin
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= report_pkg::UART_STOP;
							uart_tx_o <= 1'b1;
						end else begin
							uart_tx_o <= shift_q[0];
						end
					end
				end
				default: begin
					if (bit_done) begin
						state <= report_pkg::UART_IDLE;
					end
				end
			endcase
		end
	end

	// data leaves least significant bit first.
	always_ff @(posedge clk_i) begin
		if (state == report_pkg::UART_IDLE && tx_new_i) begin
			shift_q <= tx_data_i;
		end else if (bit_done && state != report_pkg::UART_STOP) begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

// ==== logic/report_top.sv ====
module report_top (
	input logic clk_i,
	input logic rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input report_pkg::wb_addr_t wb_adr_i,
	input report_pkg::wb_data_t wb_dat_i,
	output report_pkg::wb_data_t wb_dat_o,
	output logic wb_ack_o,
	output logic uart_tx_o
);

	logic reset_ping_waiting;
	logic reset_nonce_waiting;
	logic chip_enabled;
	logic ping_waiting;
	logic nonce_waiting;
	report_pkg::nonce_t nonce;
	report_pkg::bits_off_t bits_off;
	logic reset_byte_counter;
	logic decrement_byte_counter;
	report_pkg::tx_byte_t nonce_byte;
	report_pkg::bits_off_t nonce_bits_off;
	logic byte_counter_zero;
	logic tx_new;
	report_pkg::tx_byte_t tx_data;
	logic tx_busy;

	wb_report_regs wb_report_regs_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.reset_ping_waiting_i(reset_ping_waiting),
		.reset_nonce_waiting_i(reset_nonce_waiting),
		.chip_enabled_o(chip_enabled),
		.ping_waiting_o(ping_waiting),
		.nonce_waiting_o(nonce_waiting),
		.nonce_o(nonce),
		.bits_off_o(bits_off)
	);

	nonce_sequencer nonce_sequencer_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.nonce_i(nonce),
		.bits_off_i(bits_off),
		.reset_byte_counter_i(reset_byte_counter),
		.decrement_byte_counter_i(decrement_byte_counter),
		.nonce_byte_o(nonce_byte),
		.nonce_bits_off_o(nonce_bits_off),
		.byte_counter_zero_o(byte_counter_zero)
	);

	frame_sender frame_sender_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.tx_busy_i(tx_busy),
		.send_nonce_i(nonce_waiting),
		.send_ping_i(ping_waiting),
		.byte_counter_zero_i(byte_counter_zero),
		.chip_enabled_i(chip_enabled),
		.nonce_byte_i(nonce_byte),
		.nonce_bits_off_i(nonce_bits_off),
		.tx_new_o(tx_new),
		.tx_data_o(tx_data),
		.reset_ping_waiting_o(reset_ping_waiting),
		.reset_nonce_waiting_o(reset_nonce_waiting),
		.reset_byte_counter_o(reset_byte_counter),
		.decrement_byte_counter_o(decrement_byte_counter)
	);

	uart_tx uart_tx_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.tx_new_i(tx_new),
		.tx_data_i(tx_data),
		.tx_busy_o(tx_busy),
		.uart_tx_o(uart_tx_o)
	);

endmodule

// ==== testbench/report_tb.sv ====
module report_tb;

	// about 40 frames of at most 8 bytes at 160 cycles each, plus margin.
	localparam int TIMEOUT_CYCLES = 40 * 8 * 160 + 8800;

	logic clk_i;
	logic rst_i;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	report_pkg::wb_addr_t wb_adr_i;
	report_pkg::wb_data_t wb_dat_i;
	report_pkg::wb_data_t wb_dat_o;
	logic wb_ack_o;
	logic uart_tx_o;

	report_pkg::tx_byte_t rx_bytes[$];
	report_pkg::tx_byte_t expected_bytes[$];
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int errors_before = 0;

	logic model_enable = 1'b0;
	logic model_ping_waiting = 1'b0;
	logic model_nonce_waiting = 1'b0;
	report_pkg::nonce_t model_nonce = '0;
	report_pkg::bits_off_t model_bits_off = '0;

	report_top report_top_i (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.uart_tx_o(uart_tx_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("FAIL %0t %s: got 0x%h, expected 0x%h", $time, name, actual, expected);
			errors++;
		end
	endtask

	// ack is sampled on the falling edge, where it is stable.
	task automatic wb_access(input logic we, input report_pkg::wb_addr_t addr,
			input report_pkg::wb_data_t data_in, output report_pkg::wb_data_t data_out);
		int ack_wait;
		ack_wait = 0;
		@(posedge clk_i);
		#2;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = addr;
		wb_dat_i = data_in;
		do begin
			@(negedge clk_i);
			ack_wait++;
		end while (!wb_ack_o);
		// ack comes one clock after the strobe, so it shows at the second falling edge.
		check_value("wb_ack_o latency", ack_wait, 2);
		data_out = wb_dat_o;
		@(posedge clk_i);
		#2;
		// a classic ack lasts exactly one cycle.
		check_value("wb_ack_o", 32'(wb_ack_o), 0);
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic host_write(input report_pkg::wb_addr_t addr, input report_pkg::wb_data_t data);
		report_pkg::wb_data_t unused;
		wb_access(1'b1, addr, data, unused);
		case (addr)
			report_pkg::ADDR_CTRL: begin
				model_enable = data[0];
				if (data[1]) begin
					model_ping_waiting = 1'b1;
				end
			end
			report_pkg::ADDR_NONCE: begin
				model_nonce = data;
				model_nonce_waiting = 1'b1;
			end
			report_pkg::ADDR_BITS_OFF: model_bits_off = data[9:0];
			default: ;
		endcase
	endtask

	task automatic read_and_check(input string name, input report_pkg::wb_addr_t addr,
			input report_pkg::wb_data_t expected);
		report_pkg::wb_data_t data;
		wb_access(1'b0, addr, '0, data);
		check_value(name, data, expected);
	endtask

	function automatic report_pkg::wb_data_t expected_status();
		return {30'b0, model_nonce_waiting, model_ping_waiting};
	endfunction

	task automatic push_ping_frame();
		expected_bytes.push_back(report_pkg::CHAR_HEADER);
		expected_bytes.push_back(model_enable ? report_pkg::CHAR_PING_ON
			: report_pkg::CHAR_PING_OFF);
		expected_bytes.push_back(report_pkg::CHAR_FOOTER);
		model_ping_waiting = 1'b0;
	endtask

	task automatic push_nonce_frame();
		expected_bytes.push_back(report_pkg::CHAR_HEADER);
		expected_bytes.push_back(model_nonce[31:24]);
		expected_bytes.push_back(model_nonce[23:16]);
		expected_bytes.push_back(model_nonce[15:8]);
		expected_bytes.push_back(model_nonce[7:0]);
		expected_bytes.push_back(model_bits_off[7:0]);
		expected_bytes.push_back({6'b0, model_bits_off[9:8]});
		expected_bytes.push_back(report_pkg::CHAR_FOOTER);
		model_nonce_waiting = 1'b0;
	endtask

	task automatic expect_frames();
		while (rx_bytes.size() < expected_bytes.size()) @(posedge clk_i);
		while (expected_bytes.size() > 0) begin
			check_value("uart byte", 32'(rx_bytes.pop_front()), 32'(expected_bytes.pop_front()));
		end
	endtask

	task automatic expect_silence(input int cycles);
		repeat (cycles) @(posedge clk_i);
		check_value("bytes received while idle", rx_bytes.size(), 0);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		errors_before = errors;
	endtask

	// decodes 8N1 bytes at mid-bit on the falling clock edge.
	initial begin : uart_receiver
		report_pkg::tx_byte_t rx_byte;
		forever begin
			@(negedge uart_tx_o);
			repeat (report_pkg::CLKS_PER_BIT / 2) @(negedge clk_i);
			for (int i = 0; i < 8; i++) begin
				repeat (report_pkg::CLKS_PER_BIT) @(negedge clk_i);
				rx_byte[i] = uart_tx_o;
			end
			repeat (report_pkg::CLKS_PER_BIT) @(negedge clk_i);
			if (uart_tx_o !== 1'b1) begin
				$display("stop bit of byte 0x%h is not high at time %0t", rx_byte, $time);
				errors++;
			end
			rx_bytes.push_back(rx_byte);
		end
	end

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("timeout after %0d cycles, a frame or an ack never arrived", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		void'($urandom(32'h6355b2f8));
		repeat (16) @(posedge clk_i);
		#2;
		rst_i = 1'b0;

		check_value("uart_tx_o", 32'(uart_tx_o), 1);
		read_and_check("status", report_pkg::ADDR_STATUS, 0);
		read_and_check("ctrl", report_pkg::ADDR_CTRL, 0);
		expect_silence(400);
		finish_test("after reset");

		host_write(report_pkg::ADDR_CTRL, 32'd3);
		push_ping_frame();
		expect_frames();
		read_and_check("status", report_pkg::ADDR_STATUS, expected_status());
		finish_test("ping while enabled");

		// bits-off goes first, since the nonce write starts the frame.
		for (int i = 0; i < 20; i++) begin
			host_write(report_pkg::ADDR_BITS_OFF, $urandom);
			host_write(report_pkg::ADDR_NONCE, $urandom);
			push_nonce_frame();
			expect_frames();
		end
		finish_test("random nonce frames");

		host_write(report_pkg::ADDR_CTRL, 32'd0);
		host_write(report_pkg::ADDR_BITS_OFF, $urandom);
		host_write(report_pkg::ADDR_NONCE, $urandom);
		host_write(report_pkg::ADDR_CTRL, 32'd2);
		expect_silence(400);
		read_and_check("status", report_pkg::ADDR_STATUS, expected_status());
		host_write(report_pkg::ADDR_CTRL, 32'd1);
		push_nonce_frame();
		push_ping_frame();
		expect_frames();
		finish_test("requests while disabled");

		host_write(report_pkg::ADDR_BITS_OFF, $urandom);
		read_and_check("bits_off", report_pkg::ADDR_BITS_OFF, 32'(model_bits_off));
		host_write(report_pkg::ADDR_NONCE, $urandom);
		read_and_check("nonce", report_pkg::ADDR_NONCE, model_nonce);
		push_nonce_frame();
		expect_frames();
		host_write(report_pkg::ADDR_CTRL, 32'd0);
		read_and_check("ctrl", report_pkg::ADDR_CTRL, 0);
		host_write(report_pkg::ADDR_CTRL, 32'd1);
		read_and_check("ctrl", report_pkg::ADDR_CTRL, 1);
		finish_test("register readback");

		host_write(report_pkg::ADDR_BITS_OFF, $urandom);
		host_write(report_pkg::ADDR_NONCE, $urandom);
		push_nonce_frame();
		while (rx_bytes.size() < 2) @(posedge clk_i);
		host_write(report_pkg::ADDR_NONCE, $urandom);
		host_write(report_pkg::ADDR_BITS_OFF, $urandom);
		push_nonce_frame();
		expect_frames();
		read_and_check("status", report_pkg::ADDR_STATUS, expected_status());
		finish_test("new nonce during a frame");

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
logic/report_pkg.sv
logic/wb_report_regs.sv
logic/nonce_sequencer.sv
logic/frame_sender.sv
logic/uart_tx.sv
logic/report_top.sv
testbench/report_tb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing -f flist.f --top-module report_tb -Mdir obj_dir -o report_tb

run: compile
	./obj_dir/report_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
